/* src/motor_pkg.sv */
/*
 * Shared types and register map of the motor power stage controller.
 * Word addressed map, four 16-bit registers. Status lines are active low.
 */
package motor_pkg;

    typedef logic [1:0]         reg_addr_t;  // Register word address.
    typedef logic [15:0]        reg_data_t;  // Register data word.
    typedef logic signed [15:0] power_t;     // Signed on-cycle command.

    // Status lines in register bit order 2, 1, 0.
    typedef struct packed {
        logic drv_otw_n;     // Driver over-temperature warning.
        logic drv_fault_n;   // Driver fault.
        logic hall_fault_n;  // Hall sensor fault, reported only.
    } status_t;

    // One register access from the host.
    typedef struct packed {
        logic      read;
        logic      write;
        reg_addr_t address;
        reg_data_t writedata;
    } bus_req_t;

    // Word addresses.
    localparam reg_addr_t ADDR_STATUS  = 2'd0;  // Read only, live status.
    localparam reg_addr_t ADDR_INTFLAG = 2'd1;  // Read only, sticky flags.
    localparam reg_addr_t ADDR_FAULT   = 2'd2;  // Write only, reads zero.
    localparam reg_addr_t ADDR_POWER   = 2'd3;  // Read/write command.

    // FAULT register bits.
    localparam int FAULT_CLR_BIT = 0;
    localparam int FAULT_SET_BIT = 1;

endpackage

/* src/motor_status_monitor.sv */
/*
 * Two-flop synchronizer for the asynchronous status lines, sticky flags
 * and the fault flop. Only the two driver lines can raise fault.
 * fault_set and fault_clear are single-cycle pulses in the clk domain.
 */
module motor_status_monitor import motor_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  status_t status_raw,   // Asynchronous, active low.
    input  logic    fault_set,
    input  logic    fault_clear,
    output status_t status_sync,  // STATUS register value.
    output status_t status_flag,  // INTFLAG register value.
    output logic    fault
);

    status_t sync_meta;  // First synchronizer stage.
    logic    drv_flagged;

    // Two-flop synchronizer.
    // Idle level of the lines is high, so reset to ones.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_meta   <= '1;
            status_sync <= '1;
        end else begin
            sync_meta   <= status_raw;
            status_sync <= sync_meta;
        end
    end

    // Sticky active-low flags.
    // A clear reloads ones, ANDed with the live value so a held fault stays.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status_flag <= '1;
        end else if (fault_clear) begin
            status_flag <= status_sync;  // Same as '1 & status_sync.
        end else begin
            status_flag <= status_flag & status_sync;
        end
    end

    // Latched driver problem, Hall fault excluded.
    assign drv_flagged = !status_flag.drv_otw_n || !status_flag.drv_fault_n;

    // Fault flop.
    // Driver flags win over clear, clear wins over set.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault <= 1'b0;
        end else if (drv_flagged) begin
            fault <= 1'b1;
        end else if (fault_clear) begin
            fault <= 1'b0;
        end else if (fault_set) begin
            fault <= 1'b1;
        end
    end

    // A latched driver flag forces fault on the following cycle.
    a_drv_flag_fault : assert property (
        @(posedge clk) disable iff (reset)
        (!status_flag.drv_otw_n || !status_flag.drv_fault_n) |=> fault
    ) else $error("fault low after latched driver flag");

endmodule

/* src/motor_regs.sv */
/*
 * Register slave with plain read/write strobes and one-cycle read latency.
 * Read and write must not be high together. Unknown writes are ignored.
 * POWER is handed on as a valid/ready stream, the newest write wins.
 */
module motor_regs import motor_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  bus_req_t  bus,
    output reg_data_t readdata,
    input  status_t   status_sync,
    input  status_t   status_flag,
    output logic      fault_set,
    output logic      fault_clear,
    output power_t    cmd_data,
    output logic      cmd_valid,
    input  logic      cmd_ready
);

    logic wr_fault;  // Write hits FAULT.
    logic wr_power;  // Write hits POWER.
    logic cmd_xfer;  // Stream handshake this cycle.

    // Write decode.
    assign wr_fault = bus.write && (bus.address == ADDR_FAULT);
    assign wr_power = bus.write && (bus.address == ADDR_POWER);
    assign cmd_xfer = cmd_valid && cmd_ready;

    // Read path.
    // Data is registered, valid the cycle after read.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readdata <= '0;
        end else if (bus.read) begin
            case (bus.address)
                ADDR_STATUS:  readdata <= {13'b0, status_sync};  // Reserved bits zero.
                ADDR_INTFLAG: readdata <= {13'b0, status_flag};
                ADDR_FAULT:   readdata <= '0;                     // Write only.
                ADDR_POWER:   readdata <= reg_data_t'(cmd_data);
                default:      readdata <= '0;
            endcase
        end
    end

    // Fault pulses.
    // One cycle long, starting the cycle after the FAULT write.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault_set   <= 1'b0;
            fault_clear <= 1'b0;
        end else begin
            fault_set   <= wr_fault && bus.writedata[FAULT_SET_BIT];
            fault_clear <= wr_fault && bus.writedata[FAULT_CLR_BIT];
        end
    end

    // POWER register, doubles as the stream data.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_data <= '0;
        end else if (wr_power) begin
            cmd_data <= power_t'(bus.writedata);  // Overwrites a pending value.
        end
    end

    // Stream valid.
    // A write in the handshake cycle keeps valid up for the new value.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_valid <= 1'b0;
        end else if (wr_power) begin
            cmd_valid <= 1'b1;
        end else if (cmd_xfer) begin
            cmd_valid <= 1'b0;
        end
    end

    // Host protocol.
    a_no_rd_wr : assert property (
        @(posedge clk) disable iff (reset)
        !(bus.read && bus.write)
    ) else $error("read and write high together");

    // Held command stays put unless the host rewrites POWER.
    a_cmd_stable : assert property (
        @(posedge clk) disable iff (reset)
        (cmd_valid && !cmd_ready && !wr_power) |=> $stable(cmd_data)
    ) else $error("cmd_data changed while stalled");

endmodule

/* src/motor_pwm.sv */
/*
 * One-period PWM for a pair of half-bridge enables, no dead time.
 * Commands are taken in idle or on the last cycle of a period.
 * PWM_MAX_ON must be below PWM_PERIOD. Fault forces both enables low.
 */
module motor_pwm import motor_pkg::*; #(
    parameter int PWM_PERIOD = 3000,  // Clock cycles per period.
    parameter int PWM_MAX_ON = 2985   // Largest on-count.
) (
    input  logic   clk,
    input  logic   reset,
    input  power_t cmd_data,
    input  logic   cmd_valid,
    output logic   cmd_ready,
    input  logic   fault,
    output logic   pwm_a,
    output logic   pwm_b
);

    localparam int CNT_W = $clog2(PWM_PERIOD);

    typedef logic [CNT_W-1:0] count_t;

    typedef enum logic {
        PWM_IDLE,  // No command seen yet.
        PWM_RUN    // Periods running back to back.
    } pwm_state_t;

    pwm_state_t        state;
    count_t            cnt;       // Position in the period.
    count_t            on_len;    // Clamped magnitude.
    logic              dir_b;     // Negative command, drive side B.
    logic              last;      // Last cycle of a period.
    logic              accept;    // Command handshake.
    logic signed [16:0] cmd_ext;  // Room for the magnitude of -32768.
    logic [16:0]       cmd_mag;
    count_t            cmd_len;
    logic              pulse_on;

    assign last      = (state == PWM_RUN) && (cnt == count_t'(PWM_PERIOD - 1));
    assign cmd_ready = (state == PWM_IDLE) || last;
    assign accept    = cmd_valid && cmd_ready;

    // Magnitude and clamp of the incoming command.
    assign cmd_ext = cmd_data;
    assign cmd_mag = (cmd_ext < 0) ? 17'(-cmd_ext) : 17'(cmd_ext);
    assign cmd_len = (cmd_mag > 17'(PWM_MAX_ON)) ? count_t'(PWM_MAX_ON) : count_t'(cmd_mag);

    // State, counter and the per-period command.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= PWM_IDLE;
            cnt    <= '0;
            on_len <= '0;
            dir_b  <= 1'b0;
        end else begin
            if (accept) begin
                on_len <= cmd_len;       // Used from the next period start.
                dir_b  <= cmd_data[15];
            end
            case (state)
                PWM_IDLE: begin
                    cnt <= '0;
                    if (accept) begin
                        state <= PWM_RUN;
                    end
                end
                PWM_RUN: begin
                    cnt <= last ? '0 : cnt + count_t'(1);
                end
                default: begin
                    state <= PWM_IDLE;
                end
            endcase
        end
    end

    // Pulse covers the first on_len counts of the period.
    assign pulse_on = (state == PWM_RUN) && (cnt < on_len) && !fault;

    // Registered enables, fault gates them from the next cycle.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_a <= 1'b0;
            pwm_b <= 1'b0;
        end else begin
            pwm_a <= pulse_on && !dir_b;
            pwm_b <= pulse_on && dir_b;
        end
    end

    // Shoot-through guard.
    a_no_both : assert property (
        @(posedge clk) disable iff (reset)
        !(pwm_a && pwm_b)
    ) else $error("both half-bridge enables high");

endmodule

/* src/motor_controller_top.sv */
/*
 * Motor power stage controller top level.
 * irq is the same signal as fault. Status lines may be asynchronous.
 */
module motor_controller_top import motor_pkg::*; #(
    parameter int PWM_PERIOD = 3000,  // Clock cycles per PWM period.
    parameter int PWM_MAX_ON = 2985   // Largest on-count.
) (
    input  logic      clk,
    input  logic      reset,
    input  bus_req_t  bus,
    output reg_data_t readdata,
    input  status_t   status_raw,
    output logic      fault,
    output logic      irq,
    output logic      pwm_a,
    output logic      pwm_b
);

    status_t status_sync;  // Live status for STATUS.
    status_t status_flag;  // Sticky flags for INTFLAG.
    logic    fault_set;
    logic    fault_clear;
    power_t  cmd_data;     // POWER command stream.
    logic    cmd_valid;
    logic    cmd_ready;

    assign irq = fault;  // Single interrupt source.

    motor_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus),
        .readdata    (readdata),
        .status_sync (status_sync),
        .status_flag (status_flag),
        .fault_set   (fault_set),
        .fault_clear (fault_clear),
        .cmd_data    (cmd_data),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready)
    );

    motor_status_monitor u_monitor (
        .clk         (clk),
        .reset       (reset),
        .status_raw  (status_raw),
        .fault_set   (fault_set),
        .fault_clear (fault_clear),
        .status_sync (status_sync),
        .status_flag (status_flag),
        .fault       (fault)
    );

    motor_pwm #(
        .PWM_PERIOD (PWM_PERIOD),
        .PWM_MAX_ON (PWM_MAX_ON)
    ) u_pwm (
        .clk       (clk),
        .reset     (reset),
        .cmd_data  (cmd_data),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .fault     (fault),
        .pwm_a     (pwm_a),
        .pwm_b     (pwm_b)
    );

endmodule

/* testbench/tb_clock_gen.sv */
/*
 * Testbench clock and active-high reset.
 * Reset drops 1 time unit after the last of its rising edges.
 */
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,   // Period of 4.
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;  // Off the edge.
    end

endmodule

/* testbench/tb_motor_controller.sv */
/*
 * Testbench for motor_controller_top with 40-cycle PWM periods.
 * Status patterns are held long enough to pass the synchronizer.
 * Peeks at the top-level POWER stream valid to find the handshake.
 */
module tb_motor_controller import motor_pkg::*; ();

    localparam int PERIOD   = 40;  // Short periods.
    localparam int MAX_ON   = 37;
    localparam int HOLD     = 5;   // Cycles a status pattern is held.
    localparam int N_STATUS = 12;
    localparam int N_PWM    = 12;
    localparam int N_FIXED  = 5;
    // Reset, status, flags, faults, PWM, gating, then margin.
    localparam int TIMEOUT_CYCLES = 16 + N_STATUS * (HOLD + 3) + 120 + 200
                                  + N_PWM * 5 * PERIOD + 12 * PERIOD + 500;

    logic      clk;
    logic      reset;
    bus_req_t  bus;
    reg_data_t readdata;
    status_t   status_raw;
    logic      fault;
    logic      irq;
    logic      pwm_a;
    logic      pwm_b;

    int        seed = 52;
    int        errors = 0;
    int        checks = 0;
    int        tests = 0;
    int        test_base = 0;    // Errors before the running test.
    int        cycle_count = 0;
    status_t   model_status;     // Expected STATUS.
    status_t   model_flag;       // Expected INTFLAG.
    power_t    model_power;      // Expected POWER.
    power_t    fixed_cmds [N_FIXED] = '{16'sd0, 16'sd37, -16'sd38, 16'sd32767, -16'sd32768};
    power_t    cmd;
    logic [31:0] rnd;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    motor_controller_top #(
        .PWM_PERIOD (PERIOD),
        .PWM_MAX_ON (MAX_ON)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .readdata   (readdata),
        .status_raw (status_raw),
        .fault      (fault),
        .irq        (irq),
        .pwm_a      (pwm_a),
        .pwm_b      (pwm_b)
    );

    // Register read value, reserved bits zero, FAULT reads zero.
    function automatic reg_data_t expected_read(reg_addr_t addr, status_t st, status_t fl,
                                                power_t pw);
        case (addr)
            ADDR_STATUS:  return {13'b0, st};
            ADDR_INTFLAG: return {13'b0, fl};
            ADDR_POWER:   return reg_data_t'(pw);
            default:      return '0;
        endcase
    endfunction

    // On-count is the magnitude, clamped.
    function automatic int expected_on(power_t p);
        int mag;
        mag = (p < 0) ? -int'(p) : int'(p);
        return (mag > MAX_ON) ? MAX_ON : mag;
    endfunction

    function automatic logic expected_side_b(power_t p);
        return p < 0;  // Negative drives side B.
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;  // Drive and sample off the edge.
    endtask

    task automatic write_reg(reg_addr_t addr, reg_data_t data);
        bus.write     = 1'b1;
        bus.address   = addr;
        bus.writedata = data;
        tick();
        bus.write = 1'b0;
    endtask

    task automatic read_reg(reg_addr_t addr, output reg_data_t data);
        bus.read    = 1'b1;
        bus.address = addr;
        tick();
        bus.read = 1'b0;
        data     = readdata;  // One-cycle latency.
    endtask

    task automatic check_data(string name, reg_data_t got, reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got 0x%04h expected 0x%04h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Counts high cycles over one full period window.
    task automatic check_pwm(string name, power_t p);
        int on_a;
        int on_b;
        int exp_a;
        int exp_b;
        on_a = 0;
        on_b = 0;
        repeat (PERIOD) begin
            tick();
            on_a += pwm_a;
            on_b += pwm_b;
        end
        exp_a = expected_side_b(p) ? 0 : expected_on(p);
        exp_b = expected_side_b(p) ? expected_on(p) : 0;
        checks++;
        if (on_a != exp_a || on_b != exp_b) begin
            errors++;
            $display("[FAIL] %0t %s pwm_a/pwm_b on-counts got %0d/%0d expected %0d/%0d",
                     $time, name, on_a, on_b, exp_a, exp_b);
        end
    endtask

    task automatic read_check(string name, reg_addr_t addr);
        reg_data_t data;
        read_reg(addr, data);
        check_data(name, data, expected_read(addr, model_status, model_flag, model_power));
    endtask

    // Hold a pattern until it has reached STATUS and INTFLAG.
    task automatic set_status(status_t s);
        status_raw   = s;
        model_status = s;
        model_flag   = model_flag & s;  // Sticky low.
        repeat (HOLD) tick();
    endtask

    task automatic pulse_line(int i);
        logic [2:0] v;
        v    = 3'b111;
        v[i] = 1'b0;
        set_status(v);
        set_status(3'b111);
    endtask

    task automatic clear_fault();
        write_reg(ADDR_FAULT, reg_data_t'(1 << FAULT_CLR_BIT));
        model_flag = model_status;  // Reload, ANDed with live lines.
        repeat (3) tick();
    endtask

    // Waits until the PWM generator takes the pending command.
    task automatic wait_cmd_taken();
        int n;
        n = 0;
        while (u_dut.cmd_valid && n < 3 * PERIOD) begin
            tick();
            n++;
        end
        if (u_dut.cmd_valid) begin
            errors++;
            $display("POWER command not taken by the PWM generator within %0d cycles",
                     3 * PERIOD);
        end
    endtask

    task automatic load_power(power_t p);
        write_reg(ADDR_POWER, reg_data_t'(p));
        model_power = p;
        wait_cmd_taken();
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("test %-14s %s, %0d errors", name,
                 (errors == test_base) ? "ok" : "with errors", errors - test_base);
        test_base = errors;
    endtask

    // Run limit.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Run stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        bus          = '0;
        status_raw   = '1;  // Lines idle high.
        model_status = '1;
        model_flag   = '1;
        model_power  = '0;
        @(negedge reset);
        tick();

        // STATUS follows random patterns.
        for (int i = 0; i < N_STATUS; i++) begin
            rnd = $random(seed);
            set_status(rnd[2:0]);
            read_check("STATUS", ADDR_STATUS);
        end
        finish_test("status_read");

        // Sticky flags. First clear reloads the latch, second drops fault.
        set_status(3'b111);
        clear_fault();
        clear_fault();
        read_check("INTFLAG", ADDR_INTFLAG);
        for (int i = 0; i < 3; i++) begin
            pulse_line(i);
            read_check("INTFLAG", ADDR_INTFLAG);
            clear_fault();
            read_check("INTFLAG", ADDR_INTFLAG);  // Back to 7.
        end
        clear_fault();
        check_bit("fault", fault, 1'b0);
        finish_test("sticky_flags");

        // Driver lines raise fault.
        for (int i = 1; i < 3; i++) begin
            pulse_line(i);
            check_bit("fault", fault, 1'b1);
            check_bit("irq", irq, 1'b1);
            clear_fault();
            check_bit("fault", fault, 1'b1);  // Latched flag beats clear.
            clear_fault();
            check_bit("fault", fault, 1'b0);
            check_bit("irq", irq, 1'b0);
        end
        pulse_line(0);  // Hall only.
        check_bit("fault", fault, 1'b0);
        read_check("INTFLAG", ADDR_INTFLAG);
        clear_fault();
        write_reg(ADDR_FAULT, reg_data_t'(1 << FAULT_SET_BIT));
        repeat (2) tick();
        check_bit("fault", fault, 1'b1);
        check_bit("irq", irq, 1'b1);
        clear_fault();
        check_bit("fault", fault, 1'b0);
        set_status(3'b101);  // Driver fault held low.
        clear_fault();
        check_bit("fault", fault, 1'b1);
        set_status(3'b111);
        clear_fault();
        clear_fault();
        check_bit("fault", fault, 1'b0);
        finish_test("fault_sources");

        // POWER readback and PWM shape.
        for (int i = 0; i < N_PWM; i++) begin
            if (i < N_FIXED) begin
                cmd = fixed_cmds[i];
            end else begin
                cmd = power_t'($random(seed) % 60);  // Spans past the clamp.
            end
            load_power(cmd);
            read_check("POWER", ADDR_POWER);
            check_pwm("period", cmd);
        end
        finish_test("power_pwm");

        // Fault gating.
        load_power(16'sd25);
        write_reg(ADDR_FAULT, reg_data_t'(1 << FAULT_SET_BIT));
        repeat (2) tick();
        check_bit("fault", fault, 1'b1);
        check_pwm("gated", 16'sd0);  // Both enables off.
        clear_fault();
        check_pwm("ungated", 16'sd25);
        // Back-pressure, newest command wins.
        write_reg(ADDR_POWER, reg_data_t'(-16'sd12));
        load_power(16'sd30);
        read_check("POWER", ADDR_POWER);
        check_pwm("newest", 16'sd30);
        check_pwm("newest", 16'sd30);
        finish_test("gate_backpress");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
src/motor_pkg.sv
src/motor_status_monitor.sv
src/motor_regs.sv
src/motor_pwm.sv
src/motor_controller_top.sv
testbench/tb_clock_gen.sv
testbench/tb_motor_controller.sv

/* Bender.yml */
package:
  name: motor_controller

sources:
  - src/motor_pkg.sv
  - src/motor_status_monitor.sv
  - src/motor_regs.sv
  - src/motor_pwm.sv
  - src/motor_controller_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_motor_controller.sv
